// File: Bender.yml
package:
  name: exu

sources:
  - design/exu_pkg.sv
  - design/exu_shift.sv
  - design/exu_alu.sv
  - design/exu_csr_file.sv
  - design/exu_ctrl.sv
  - design/exu_top.sv
  - target: simulation
    files:
      - sim/exu_tb.sv

// File: compile.f
design/exu_pkg.sv
design/exu_shift.sv
design/exu_alu.sv
design/exu_csr_file.sv
design/exu_ctrl.sv
design/exu_top.sv
sim/exu_tb.sv

// File: design/exu_alu.sv
// exu ALU
// combinational integer ALU: one shared adder for add, sub and the
// compares, logic ops, the barrel shifter, and the CSR write-data mux
`timescale 1ns/1ps

module exu_alu (
    input  logic [exu_pkg::XLEN-1:0]     da,
    input  logic [exu_pkg::XLEN-1:0]     db,
    input  logic [exu_pkg::ALU_OP_W-1:0] alu_op,
    input  logic [exu_pkg::XLEN-1:0]     rs1,
    input  logic [exu_pkg::XLEN-1:0]     pc,
    input  logic [exu_pkg::XLEN-1:0]     csr_rdata,
    input  logic                         csr_op_rs,
    input  logic                         csr_op_rw,
    input  logic                         csr_op_ecall,
    output logic [exu_pkg::XLEN-1:0]     alu_out,
    output logic                         alu_less,
    output logic                         alu_zero,
    output logic [exu_pkg::XLEN-1:0]     alu_csr_out
);

    logic                     sub_en;
    logic [exu_pkg::XLEN-1:0] db_x;
    logic [exu_pkg::XLEN-1:0] sum;
    logic                     carry;
    logic                     ovf;
    logic [exu_pkg::XLEN-1:0] shift_out;
    logic [exu_pkg::XLEN-1:0] less_w;

    // ======================================================================
    // adder
    assign sub_en = alu_op[exu_pkg::OP_SUB] | alu_op[exu_pkg::OP_SLT] | alu_op[exu_pkg::OP_SLTU];
    assign db_x   = db ^ {exu_pkg::XLEN{sub_en}};   // invert b, +1 through carry in

    assign {carry, sum} = {1'b0, da} + {1'b0, db_x} + {{exu_pkg::XLEN{1'b0}}, sub_en};

    assign ovf      = (da[exu_pkg::XLEN-1] == db_x[exu_pkg::XLEN-1])
                    & (da[exu_pkg::XLEN-1] != sum[exu_pkg::XLEN-1]);
    assign alu_zero = (sum == '0);
    // no carry out of a - b means a < b unsigned
    assign alu_less = alu_op[exu_pkg::OP_SLTU] ? ~carry : (ovf ^ sum[exu_pkg::XLEN-1]);
    assign less_w   = {{(exu_pkg::XLEN-1){1'b0}}, alu_less};

    exu_shift u_shift (
        .din   (da),
        .shamt (db[4:0]),
        .left  (alu_op[exu_pkg::OP_SLL]),
        .arith (alu_op[exu_pkg::OP_SRA]),
        .dout  (shift_out)
    );

    // ======================================================================
    // result select, AND-OR across the one-hot op
    assign alu_out = ({exu_pkg::XLEN{alu_op[exu_pkg::OP_ADD]}}  & sum)       |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_SUB]}}  & sum)       |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_SLT]}}  & less_w)    |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_SLTU]}} & less_w)    |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_OR]}}   & (da | db)) |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_AND]}}  & (da & db)) |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_XOR]}}  & (da ^ db)) |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_SLL]}}  & shift_out) |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_SRL]}}  & shift_out) |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_SRA]}}  & shift_out) |
                     ({exu_pkg::XLEN{alu_op[exu_pkg::OP_PASS]}} & db);

    // data headed for the CSR file; ecall stores the pc into mepc
    assign alu_csr_out = ({exu_pkg::XLEN{csr_op_rs}}    & (rs1 | csr_rdata)) |
                         ({exu_pkg::XLEN{csr_op_rw}}    & rs1)               |
                         ({exu_pkg::XLEN{csr_op_ecall}} & pc);

    // decode in exu_ctrl must never select two ops at once
    always_comb begin
        if (!$isunknown(alu_op)) begin
            assert final ($onehot0(alu_op))
                else $error("alu_op has more than one bit set: %b", alu_op);
        end
    end

endmodule

// File: design/exu_csr_file.sv
// exu CSR file
// mstatus, mtvec, mepc and mcause with a combinational read port,
// a write port updated on the strobe edge, and ecall capture
`timescale 1ns/1ps

module exu_csr_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [11:0]              csr_addr,
    input  logic                     csr_wr_en,
    input  logic                     csr_ecall,
    input  logic [exu_pkg::XLEN-1:0] csr_wdata,
    output logic [exu_pkg::XLEN-1:0] csr_rdata,
    output logic [exu_pkg::XLEN-1:0] mtvec
);

    logic [exu_pkg::XLEN-1:0] mstatus;
    logic [exu_pkg::XLEN-1:0] mepc;
    logic [exu_pkg::XLEN-1:0] mcause;

    // ======================================================================
    // read port, unknown addresses give 0
    always_comb begin
        case (csr_addr)
            exu_pkg::CSR_MSTATUS: csr_rdata = mstatus;
            exu_pkg::CSR_MTVEC:   csr_rdata = mtvec;
            exu_pkg::CSR_MEPC:    csr_rdata = mepc;
            exu_pkg::CSR_MCAUSE:  csr_rdata = mcause;
            default:              csr_rdata = '0;
        endcase
    end

    // ======================================================================
    // write port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (csr_wr_en) begin
            if (csr_ecall) begin
                mepc   <= csr_wdata;              // pc of the ecall
                mcause <= exu_pkg::CAUSE_ECALL_M;
            end else begin
                case (csr_addr)
                    exu_pkg::CSR_MSTATUS: mstatus <= csr_wdata;
                    exu_pkg::CSR_MTVEC:   mtvec   <= csr_wdata;
                    exu_pkg::CSR_MEPC:    mepc    <= csr_wdata;
                    exu_pkg::CSR_MCAUSE:  mcause  <= csr_wdata;
                    default: ;                    // write dropped
                endcase
            end
        end
    end

    // ecall capture only happens as part of a write from the control block
    assert property (@(posedge clk) disable iff (!rst_n) csr_ecall |-> csr_wr_en)
        else $error("csr_ecall raised without csr_wr_en");

endmodule

// File: design/exu_ctrl.sv
// exu control
// decodes the instruction word, picks ALU operands and op, resolves
// branches and ecall, drives the CSR port, and registers the result
`timescale 1ns/1ps

module exu_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [exu_pkg::XLEN-1:0]     in_instr,
    input  logic [exu_pkg::XLEN-1:0]     in_pc,
    input  logic [exu_pkg::XLEN-1:0]     rs1_data,
    input  logic [exu_pkg::XLEN-1:0]     rs2_data,
    output logic [exu_pkg::XLEN-1:0]     alu_da,
    output logic [exu_pkg::XLEN-1:0]     alu_db,
    output logic [exu_pkg::ALU_OP_W-1:0] alu_op,
    output logic [exu_pkg::XLEN-1:0]     alu_rs1,
    output logic [exu_pkg::XLEN-1:0]     alu_pc,
    output logic                         csr_op_rs,
    output logic                         csr_op_rw,
    output logic                         csr_op_ecall,
    input  logic [exu_pkg::XLEN-1:0]     alu_out,
    input  logic                         alu_less,
    input  logic                         alu_zero,
    output logic [11:0]                  csr_addr,
    output logic                         csr_wr_en,
    output logic                         csr_ecall,
    input  logic [exu_pkg::XLEN-1:0]     csr_rdata,
    input  logic [exu_pkg::XLEN-1:0]     mtvec,
    output logic                         out_valid,
    output logic [4:0]                   out_rd,
    output logic                         out_wr_en,
    output logic [exu_pkg::XLEN-1:0]     out_result,
    output logic                         redirect,
    output logic [exu_pkg::XLEN-1:0]     redirect_pc
);

    exu_pkg::instr_u          ins;
    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [4:0]               rd;
    logic [exu_pkg::XLEN-1:0] imm_i, imm_b, imm_u;
    logic                     is_op, is_imm, is_lui, is_br, is_sys, is_csr;
    logic                     taken;

    assign ins    = in_instr;
    assign opcode = ins.r_view.opcode;
    assign funct3 = ins.i_view.funct3;
    assign rd     = ins.u_view.rd;

    assign imm_i = {{20{ins.i_view.imm12[11]}}, ins.i_view.imm12};
    assign imm_u = {ins.u_view.imm20, 12'b0};
    assign imm_b = {{20{ins.b_view.imm12}}, ins.b_view.imm11, ins.b_view.imm10_5,
                    ins.b_view.imm4_1, 1'b0};

    assign is_op  = (opcode == exu_pkg::OPC_OP);
    assign is_imm = (opcode == exu_pkg::OPC_OP_IMM);
    assign is_lui = (opcode == exu_pkg::OPC_LUI);
    assign is_br  = (opcode == exu_pkg::OPC_BRANCH);
    assign is_sys = (opcode == exu_pkg::OPC_SYSTEM);

    assign csr_op_rw    = is_sys & (funct3 == exu_pkg::F3_CSRRW);
    assign csr_op_rs    = is_sys & (funct3 == exu_pkg::F3_CSRRS);
    assign csr_op_ecall = is_sys & (funct3 == 3'b000) & (ins.i_view.imm12 == 12'h000);
    assign is_csr       = csr_op_rw | csr_op_rs;

    // ======================================================================
    // operands and op select
    assign alu_da  = rs1_data;
    assign alu_db  = is_imm ? imm_i : (is_lui ? imm_u : rs2_data);
    assign alu_rs1 = rs1_data;
    assign alu_pc  = in_pc;

    always_comb begin
        alu_op = '0;
        if (is_op || is_imm) begin
            case (funct3)
                exu_pkg::F3_ADD_SUB: begin
                    if (is_op && ins.r_view.funct7[5]) alu_op[exu_pkg::OP_SUB] = 1'b1;
                    else                               alu_op[exu_pkg::OP_ADD] = 1'b1;
                end
                exu_pkg::F3_SLL:  alu_op[exu_pkg::OP_SLL]  = 1'b1;
                exu_pkg::F3_SLT:  alu_op[exu_pkg::OP_SLT]  = 1'b1;
                exu_pkg::F3_SLTU: alu_op[exu_pkg::OP_SLTU] = 1'b1;
                exu_pkg::F3_XOR:  alu_op[exu_pkg::OP_XOR]  = 1'b1;
                exu_pkg::F3_OR:   alu_op[exu_pkg::OP_OR]   = 1'b1;
                exu_pkg::F3_AND:  alu_op[exu_pkg::OP_AND]  = 1'b1;
                default: begin                                   // srl / sra
                    if (ins.r_view.funct7[5]) alu_op[exu_pkg::OP_SRA] = 1'b1;
                    else                      alu_op[exu_pkg::OP_SRL] = 1'b1;
                end
            endcase
        end else if (is_lui) begin
            alu_op[exu_pkg::OP_PASS] = 1'b1;
        end else if (is_br) begin
            // unsigned compares need the sltu flavour of less
            if (funct3 == exu_pkg::F3_BLTU || funct3 == exu_pkg::F3_BGEU)
                alu_op[exu_pkg::OP_SLTU] = 1'b1;
            else
                alu_op[exu_pkg::OP_SUB] = 1'b1;
        end
    end

    always_comb begin
        case (funct3)
            exu_pkg::F3_BEQ:                   taken = alu_zero;
            exu_pkg::F3_BNE:                   taken = ~alu_zero;
            exu_pkg::F3_BLT, exu_pkg::F3_BLTU: taken = alu_less;
            exu_pkg::F3_BGE, exu_pkg::F3_BGEU: taken = ~alu_less;
            default:                           taken = 1'b0;
        endcase
    end

    // CSR port, written on the strobe edge
    assign csr_addr  = ins.i_view.imm12;
    assign csr_wr_en = in_valid & (is_csr | csr_op_ecall);
    assign csr_ecall = in_valid & csr_op_ecall;

    // ======================================================================
    // output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_wr_en <= 1'b0;
            redirect  <= 1'b0;
        end else begin
            out_valid <= in_valid;
            out_wr_en <= in_valid & (is_op | is_imm | is_lui | is_csr) & (rd != 5'd0);
            redirect  <= in_valid & ((is_br & taken) | csr_op_ecall);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_rd      <= rd;
            out_result  <= is_csr ? csr_rdata : alu_out;   // old CSR value
            redirect_pc <= csr_op_ecall ? mtvec : in_pc + imm_b;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) in_valid |=> out_valid)
        else $error("out_valid missing one cycle after in_valid");
    assert property (@(posedge clk) disable iff (!rst_n) !in_valid |=> !out_valid)
        else $error("out_valid without a strobe one cycle earlier");
    assert property (@(posedge clk) disable iff (!rst_n) redirect |-> out_valid)
        else $error("redirect raised without out_valid");

endmodule

// File: design/exu_pkg.sv
// exu package
// shared constants for the execute stage: widths, one-hot ALU op
// indices, RV32I opcodes and funct3 codes, machine CSR addresses,
// and the instruction word union with its four field layouts
package exu_pkg;

    localparam int XLEN     = 32;
    localparam int ALU_OP_W = 11;

    // ======================================================================
    // one-hot ALU op bit positions
    localparam int OP_ADD  = 0;
    localparam int OP_SUB  = 1;
    localparam int OP_SLT  = 2;
    localparam int OP_SLTU = 3;
    localparam int OP_OR   = 4;
    localparam int OP_AND  = 5;
    localparam int OP_XOR  = 6;
    localparam int OP_SLL  = 7;
    localparam int OP_SRL  = 8;
    localparam int OP_SRA  = 9;
    localparam int OP_PASS = 10;  // forwards operand b, used by lui

    // ======================================================================
    // opcodes and funct3
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl/sra, split by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;

    // ======================================================================
    // machine CSRs
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

    // one instruction word, four ways of reading its fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic       imm12;     // sign bit of the offset
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_view;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_view;
    } instr_u;

endpackage

// File: design/exu_shift.sv
// exu shifter
// five-stage barrel shifter for sll, srl and sra; left shifts run
// through the right-shift stages on a bit-reversed word
`timescale 1ns/1ps

module exu_shift (
    input  logic [exu_pkg::XLEN-1:0] din,
    input  logic [4:0]               shamt,
    input  logic                     left,
    input  logic                     arith,
    output logic [exu_pkg::XLEN-1:0] dout
);

    logic [5:0][exu_pkg::XLEN-1:0] stage;
    logic                          fill;

    function automatic logic [exu_pkg::XLEN-1:0] bit_rev(input logic [exu_pkg::XLEN-1:0] v);
        logic [exu_pkg::XLEN-1:0] r;
        for (int i = 0; i < exu_pkg::XLEN; i++) begin
            r[i] = v[exu_pkg::XLEN-1-i];
        end
        return r;
    endfunction

    assign fill     = arith & ~left & din[exu_pkg::XLEN-1];  // sign fill for sra only
    assign stage[0] = left ? bit_rev(din) : din;

    // stage s shifts right by 2**s when shamt[s] is set
    for (genvar s = 0; s < 5; s++) begin : g_stage
        localparam int N = 1 << s;
        assign stage[s+1] = shamt[s] ? {{N{fill}}, stage[s][exu_pkg::XLEN-1:N]} : stage[s];
    end

    assign dout = left ? bit_rev(stage[5]) : stage[5];

endmodule

// File: design/exu_top.sv
// exu top
// execute stage of the RV32I core: control and output register, ALU,
// and the machine CSR file, wired together
`timescale 1ns/1ps

module exu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic [exu_pkg::XLEN-1:0] in_instr,
    input  logic [exu_pkg::XLEN-1:0] in_pc,
    input  logic [exu_pkg::XLEN-1:0] rs1_data,
    input  logic [exu_pkg::XLEN-1:0] rs2_data,
    output logic                     out_valid,
    output logic [4:0]               out_rd,
    output logic                     out_wr_en,
    output logic [exu_pkg::XLEN-1:0] out_result,
    output logic                     redirect,
    output logic [exu_pkg::XLEN-1:0] redirect_pc
);

    // ctrl to ALU
    logic [exu_pkg::XLEN-1:0]     alu_da, alu_db, alu_rs1, alu_pc;
    logic [exu_pkg::ALU_OP_W-1:0] alu_op;
    logic                         csr_op_rs, csr_op_rw, csr_op_ecall;
    // ALU back
    logic [exu_pkg::XLEN-1:0]     alu_out, alu_csr_out;
    logic                         alu_less, alu_zero;
    // CSR file
    logic [11:0]                  csr_addr;
    logic                         csr_wr_en, csr_ecall;
    logic [exu_pkg::XLEN-1:0]     csr_rdata, mtvec;

    exu_ctrl u_ctrl (
        .clk          (clk),          .rst_n       (rst_n),
        .in_valid     (in_valid),     .in_instr    (in_instr),
        .in_pc        (in_pc),        .rs1_data    (rs1_data),
        .rs2_data     (rs2_data),     .alu_da      (alu_da),
        .alu_db       (alu_db),       .alu_op      (alu_op),
        .alu_rs1      (alu_rs1),      .alu_pc      (alu_pc),
        .csr_op_rs    (csr_op_rs),    .csr_op_rw   (csr_op_rw),
        .csr_op_ecall (csr_op_ecall), .alu_out     (alu_out),
        .alu_less     (alu_less),     .alu_zero    (alu_zero),
        .csr_addr     (csr_addr),     .csr_wr_en   (csr_wr_en),
        .csr_ecall    (csr_ecall),    .csr_rdata   (csr_rdata),
        .mtvec        (mtvec),        .out_valid   (out_valid),
        .out_rd       (out_rd),       .out_wr_en   (out_wr_en),
        .out_result   (out_result),   .redirect    (redirect),
        .redirect_pc  (redirect_pc)
    );

    exu_alu u_alu (
        .da           (alu_da),       .db          (alu_db),
        .alu_op       (alu_op),       .rs1         (alu_rs1),
        .pc           (alu_pc),       .csr_rdata   (csr_rdata),
        .csr_op_rs    (csr_op_rs),    .csr_op_rw   (csr_op_rw),
        .csr_op_ecall (csr_op_ecall), .alu_out     (alu_out),
        .alu_less     (alu_less),     .alu_zero    (alu_zero),
        .alu_csr_out  (alu_csr_out)
    );

    exu_csr_file u_csr (
        .clk       (clk),       .rst_n     (rst_n),
        .csr_addr  (csr_addr),  .csr_wr_en (csr_wr_en),
        .csr_ecall (csr_ecall), .csr_wdata (alu_csr_out),
        .csr_rdata (csr_rdata), .mtvec     (mtvec)
    );

endmodule

// File: sim/exu_tb.sv
// exu testbench
// directed tests for the execute stage, checked against a model of the
// RV32I ALU, branch and machine CSR rules kept in the testbench
`timescale 1ns/1ps

module exu_tb;

    localparam int CLK_NS      = 4;
    localparam int MAX_TXN     = 600;
    localparam int WATCHDOG_NS = MAX_TXN * 2 * CLK_NS * 4 + 800;  // 20 us

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] in_instr, in_pc, rs1_data, rs2_data;
    logic        out_valid, out_wr_en, redirect;
    logic [4:0]  out_rd;
    logic [31:0] out_result, redirect_pc;
    logic [31:0] m_mstatus, m_mtvec, m_mepc, m_mcause;   // model CSRs
    int unsigned seed_draw;
    int          errors = 0;

    always #(CLK_NS / 2) clk = ~clk;

    exu_top u_exu_top (
        .clk        (clk),        .rst_n       (rst_n),
        .in_valid   (in_valid),   .in_instr    (in_instr),
        .in_pc      (in_pc),      .rs1_data    (rs1_data),
        .rs2_data   (rs2_data),   .out_valid   (out_valid),
        .out_rd     (out_rd),     .out_wr_en   (out_wr_en),
        .out_result (out_result), .redirect    (redirect),
        .redirect_pc(redirect_pc)
    );

    // ======================================================================
    // instruction encoding and reference model
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        exu_pkg::instr_u w;
        w.r_view = '{funct7: f7, rs2: 5'd2, rs1: 5'd1, funct3: f3, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        exu_pkg::instr_u w;
        w.i_view = '{imm12: imm, rs1: 5'd1, funct3: f3, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [2:0] f3);
        exu_pkg::instr_u w;
        w.b_view = '{imm12: off[12], imm10_5: off[10:5], rs2: 5'd2, rs1: 5'd1,
                     funct3: f3, imm4_1: off[4:1], imm11: off[11],
                     opcode: exu_pkg::OPC_BRANCH};
        return w;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I integer op with the low 5 bits of b as shift amount
    function automatic logic [31:0] rv_op(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            exu_pkg::F3_ADD_SUB: return alt ? a - b : a + b;
            exu_pkg::F3_SLL:     return a << b[4:0];
            exu_pkg::F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
            exu_pkg::F3_SLTU:    return {31'b0, a < b};
            exu_pkg::F3_XOR:     return a ^ b;
            exu_pkg::F3_SR:      return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            exu_pkg::F3_OR:      return a | b;
            default:             return a & b;
        endcase
    endfunction

    function automatic logic br_taken(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            exu_pkg::F3_BEQ:  return a == b;
            exu_pkg::F3_BNE:  return a != b;
            exu_pkg::F3_BLT:  return $signed(a) < $signed(b);
            exu_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            exu_pkg::F3_BLTU: return a < b;
            default:          return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] csr_model_read(input logic [11:0] addr);
        case (addr)
            exu_pkg::CSR_MSTATUS: return m_mstatus;
            exu_pkg::CSR_MTVEC:   return m_mtvec;
            exu_pkg::CSR_MEPC:    return m_mepc;
            exu_pkg::CSR_MCAUSE:  return m_mcause;
            default:              return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h8000_0000;   // sign boundaries
            1:       return 32'h7fff_ffff;
            2:       return 32'h0;
            3:       return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    // ======================================================================
    // drive and check
    task automatic check_val(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s %s: expected %h, actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the result edge
    task automatic run_one(input string name, input logic [31:0] instr, pc, a, b,
                           input logic exp_wr, input logic chk_res, input logic [4:0] exp_rd,
                           input logic [31:0] exp_res, input logic exp_redir,
                           input logic [31:0] exp_rpc);
        int waited;
        in_valid = 1'b1;
        in_instr = instr;
        in_pc    = pc;
        rs1_data = a;
        rs2_data = b;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        waited   = 0;
        while (out_valid !== 1'b1 && waited < 4) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (out_valid !== 1'b1) begin
            $display("%s: out_valid never came after the strobe", name);
            errors++;
        end else begin
            check_val(name, "out_wr_en", exp_wr, out_wr_en);
            check_val(name, "redirect", exp_redir, redirect);
            if (chk_res) begin
                check_val(name, "out_rd", exp_rd, out_rd);
                check_val(name, "out_result", exp_res, out_result);
            end
            if (exp_redir) check_val(name, "redirect_pc", exp_rpc, redirect_pc);
        end
    endtask

    task automatic csr_access(input string name, input logic [2:0] f3,
                              input logic [11:0] addr, input logic [31:0] val,
                              input logic [4:0] rd);
        logic [31:0] old_v;
        logic [31:0] new_v;
        old_v = csr_model_read(addr);
        new_v = (f3 == exu_pkg::F3_CSRRS) ? (old_v | val) : val;
        run_one(name, enc_i(addr, f3, rd, exu_pkg::OPC_SYSTEM), 32'h100, val, 32'h0,
                rd != 0, 1'b1, rd, old_v, 1'b0, 32'h0);
        case (addr)
            exu_pkg::CSR_MSTATUS: m_mstatus = new_v;
            exu_pkg::CSR_MTVEC:   m_mtvec   = new_v;
            exu_pkg::CSR_MEPC:    m_mepc    = new_v;
            exu_pkg::CSR_MCAUSE:  m_mcause  = new_v;
            default: ;   // unknown address keeps nothing
        endcase
    endtask

    // ======================================================================
    // tests
    task automatic reg_reg_test();
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [31:0] a, b;
        for (int i = 0; i < 200; i++) begin
            f3  = $urandom_range(0, 7);
            alt = (f3 == exu_pkg::F3_ADD_SUB || f3 == exu_pkg::F3_SR) ? $urandom_range(0, 1) : 0;
            rd  = $urandom_range(1, 31);
            a   = pick_operand();
            b   = pick_operand();
            run_one("reg_reg", enc_r({1'b0, alt, 5'b0}, f3, rd, exu_pkg::OPC_OP),
                    32'h0, a, b, 1'b1, 1'b1, rd, rv_op(f3, alt, a, b), 1'b0, 32'h0);
        end
    endtask

    task automatic imm_lui_test();
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [19:0] imm20;
        logic [31:0] a;
        for (int i = 0; i < 40; i++) begin
            f3  = $urandom_range(0, 7);
            alt = (f3 == exu_pkg::F3_SR) ? $urandom_range(0, 1) : 0;
            imm = $urandom;
            if (f3 == exu_pkg::F3_SLL || f3 == exu_pkg::F3_SR) imm[11:5] = {1'b0, alt, 5'b0};
            rd  = (i % 8 == 0) ? 5'd0 : 5'($urandom_range(1, 31));
            a   = pick_operand();
            run_one("op_imm", enc_i(imm, f3, rd, exu_pkg::OPC_OP_IMM), 32'h0, a, 32'h0,
                    rd != 0, 1'b1, rd, rv_op(f3, alt, a, sext12(imm)), 1'b0, 32'h0);
        end
        for (int i = 0; i < 10; i++) begin
            imm20 = $urandom;
            rd    = (i == 0) ? 5'd0 : 5'($urandom_range(1, 31));
            run_one("lui", {imm20, rd, exu_pkg::OPC_LUI}, 32'h0, $urandom, $urandom,
                    rd != 0, 1'b1, rd, {imm20, 12'b0}, 1'b0, 32'h0);
        end
    endtask

    task automatic branch_test();
        logic [2:0]  conds[6];
        logic [2:0]  f3;
        logic [31:0] a, b, pc, r;
        logic [12:0] off;
        conds = '{exu_pkg::F3_BEQ, exu_pkg::F3_BNE, exu_pkg::F3_BLT,
                  exu_pkg::F3_BGE, exu_pkg::F3_BLTU, exu_pkg::F3_BGEU};
        for (int i = 0; i < 60; i++) begin
            f3  = conds[i % 6];
            a   = pick_operand();
            b   = ($urandom_range(0, 3) == 0) ? a : pick_operand();
            pc  = $urandom & 32'hffff_fffc;
            r   = $urandom;
            off = {r[11:0], 1'b0};
            run_one("branch", enc_b(off, f3), pc, a, b, 1'b0, 1'b0, 5'd0, 32'h0,
                    br_taken(f3, a, b), pc + {{19{off[12]}}, off});
        end
    endtask

    task automatic csr_test();
        csr_access("csrrw mtvec", exu_pkg::F3_CSRRW, exu_pkg::CSR_MTVEC, $urandom, 5'd5);
        csr_access("csrrs mtvec", exu_pkg::F3_CSRRS, exu_pkg::CSR_MTVEC, $urandom, 5'd6);
        csr_access("csrrs mtvec rd", exu_pkg::F3_CSRRS, exu_pkg::CSR_MTVEC, 32'h0, 5'd7);
        csr_access("csrrw mstatus", exu_pkg::F3_CSRRW, exu_pkg::CSR_MSTATUS, $urandom, 5'd8);
        csr_access("csrrs mstatus", exu_pkg::F3_CSRRS, exu_pkg::CSR_MSTATUS, 32'h0, 5'd9);
        csr_access("csrrw unknown", exu_pkg::F3_CSRRW, 12'h340, $urandom, 5'd10);
        csr_access("csrrs unknown", exu_pkg::F3_CSRRS, 12'h340, 32'h0, 5'd11);
        csr_access("csrrw mepc", exu_pkg::F3_CSRRW, exu_pkg::CSR_MEPC, $urandom, 5'd0);
        csr_access("csrrs mepc", exu_pkg::F3_CSRRS, exu_pkg::CSR_MEPC, 32'h0, 5'd12);
    endtask

    task automatic ecall_test();
        logic [31:0] pc;
        pc = $urandom & 32'hffff_fffc;
        csr_access("set mtvec", exu_pkg::F3_CSRRW, exu_pkg::CSR_MTVEC, 32'h0000_8000, 5'd1);
        run_one("ecall", 32'h0000_0073, pc, $urandom, $urandom, 1'b0, 1'b0, 5'd0, 32'h0,
                1'b1, m_mtvec);
        m_mepc   = pc;
        m_mcause = 32'd11;
        csr_access("read mepc", exu_pkg::F3_CSRRS, exu_pkg::CSR_MEPC, 32'h0, 5'd3);
        csr_access("read mcause", exu_pkg::F3_CSRRS, exu_pkg::CSR_MCAUSE, 32'h0, 5'd4);
    endtask

    task automatic idle_test(input string name);
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #1;
            check_val(name, "out_valid", 1'b0, out_valid);
            check_val(name, "out_wr_en", 1'b0, out_wr_en);
            check_val(name, "redirect", 1'b0, redirect);
        end
    endtask

    // three addi on consecutive cycles with results following in order
    task automatic back_to_back_test();
        logic [31:0] a[3];
        logic [11:0] imm[3];
        for (int i = 0; i < 3; i++) begin
            a[i]   = $urandom;
            imm[i] = $urandom;
        end
        for (int i = 0; i <= 3; i++) begin
            in_valid = (i < 3);
            if (i < 3) begin
                in_instr = enc_i(imm[i], exu_pkg::F3_ADD_SUB, 5'(i + 1), exu_pkg::OPC_OP_IMM);
                rs1_data = a[i];
            end
            if (i > 0) begin
                check_val("back_to_back", "out_valid", 1'b1, out_valid);
                check_val("back_to_back", "out_rd", i, out_rd);
                check_val("back_to_back", "out_result", a[i-1] + sext12(imm[i-1]), out_result);
            end
            @(posedge clk);
            #1;
        end
        check_val("back_to_back", "out_valid", 1'b0, out_valid);
    endtask

    // ======================================================================
    // main sequence and watchdog
    initial begin
        seed_draw = $urandom(32'he6dd4ee6);
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = 32'h0;
        in_pc     = 32'h0;
        rs1_data  = 32'h0;
        rs2_data  = 32'h0;
        m_mstatus = 32'h0;
        m_mtvec   = 32'h0;
        m_mepc    = 32'h0;
        m_mcause  = 32'h0;
        // strobes during reset alternate an addi to x1 and an ecall
        for (int i = 0; i < 8; i++) begin
            in_valid = (i < 7);   // dropped before reset is released
            if (i % 2 == 0) begin
                in_instr = enc_i(12'h001, exu_pkg::F3_ADD_SUB, 5'd1, exu_pkg::OPC_OP_IMM);
            end else begin
                in_instr = 32'h0000_0073;
            end
            @(posedge clk);
            #1;
            check_val("reset", "out_valid", 1'b0, out_valid);
            check_val("reset", "out_wr_en", 1'b0, out_wr_en);
            check_val("reset", "redirect", 1'b0, redirect);
        end
        rst_n    = 1'b1;
        in_instr = 32'h0;
        idle_test("idle after reset");
        back_to_back_test();
        reg_reg_test();
        imm_lui_test();
        branch_test();
        csr_test();
        ecall_test();
        idle_test("idle at end");
        $display("exu_tb finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule
